//--- exec_pkg.sv
package exec_pkg;

	localparam int DATA_W      = 16;
	localparam int PREG_NUM    = 64;
	localparam int PREG_W      = 6;
	localparam int ROB_IDX_W   = 6;
	localparam int MULT_STAGES = 2;

	// alu1 src1/src2, alu2 src1/src2, mult src1/src2, agen base
	localparam int RD_PORTS = 7;
	// alu1, alu2, mult
	localparam int WR_PORTS = 3;

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [PREG_W-1:0]    preg_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;

	// shifts take opb[3:0], LDI passes opb through
	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4,
		SLL = 3'd5,
		SRL = 3'd6,
		LDI = 3'd7
	} alu_op_e;

	typedef struct packed {
		logic     vld;
		rob_idx_t rob_idx;
		preg_t    src1;
		preg_t    src2;
		preg_t    dst;
		logic     reg_wrt;
		logic     imm_vld;
		data_t    imm;
		alu_op_e  op;
	} issue_pkt_t;

	// operands already picked from regfile or imm
	typedef struct packed {
		logic     vld;
		rob_idx_t rob_idx;
		preg_t    dst;
		logic     reg_wrt;
		alu_op_e  op;
		data_t    opa;
		data_t    opb;
	} exec_op_t;

	typedef struct packed {
		logic     vld;
		rob_idx_t rob_idx;
		logic     reg_wrt;
		preg_t    dst;
		data_t    data;
	} done_t;

	typedef struct packed {
		logic     vld;
		rob_idx_t rob_idx;
		data_t    addr;
	} agen_t;

	typedef struct packed {
		logic  en;
		preg_t dst;
		data_t data;
	} wr_req_t;

endpackage

//--- phys_reg_file.sv
`timescale 1ns/10ps

module phys_reg_file import exec_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  preg_t   rd_addr [RD_PORTS],
	output data_t   rd_data [RD_PORTS],
	input  wr_req_t wr_req  [WR_PORTS]
);

	data_t regs [PREG_NUM];

	// no bypass so a write shows up on the cycle after its edge
	genvar r;
	generate
		for (r = 0; r < RD_PORTS; r++) begin : g_rd
			assign rd_data[r] = regs[rd_addr[r]];
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < PREG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int w = 0; w < WR_PORTS; w++) begin
				if (wr_req[w].en) begin
					regs[wr_req[w].dst] <= wr_req[w].data;
				end
			end
		end
	end

	// destinations come from issue, so two lanes retiring to one
	// preg in the same cycle means the scheduler broke
	genvar a, b;
	generate
		for (a = 0; a < WR_PORTS; a++) begin : g_wa
			for (b = a + 1; b < WR_PORTS; b++) begin : g_wb
				a_wr_unique: assert property (@(posedge clk) disable iff (rst)
					!(wr_req[a].en && wr_req[b].en && (wr_req[a].dst == wr_req[b].dst)))
					else $error("write ports %0d and %0d hit preg %0d", a, b, wr_req[a].dst);
			end
		end
	endgenerate

endmodule

//--- operand_fetch.sv
`timescale 1ns/10ps

module operand_fetch import exec_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  issue_pkt_t alu1_issue,
	input  issue_pkt_t alu2_issue,
	input  issue_pkt_t mult_issue,
	input  issue_pkt_t agen_issue,
	output preg_t      rd_addr [RD_PORTS],
	input  data_t      rd_data [RD_PORTS],
	output exec_op_t   alu1_op,
	output exec_op_t   alu2_op,
	output exec_op_t   mult_op,
	output agen_t      agen_op
);

	issue_pkt_t alu1_q;
	issue_pkt_t alu2_q;
	issue_pkt_t mult_q;
	issue_pkt_t agen_q;
	data_t      agen_addr;

	function automatic exec_op_t to_exec(input issue_pkt_t p, input data_t a, input data_t b);
		exec_op_t o;
		o.vld     = p.vld;
		o.rob_idx = p.rob_idx;
		o.dst     = p.dst;
		o.reg_wrt = p.reg_wrt;
		o.op      = p.op;
		o.opa     = a;
		// imm replaces the second source
		o.opb     = p.imm_vld ? p.imm : b;
		return o;
	endfunction

	// IS/RF
	always_ff @(posedge clk) begin
		if (rst) begin
			alu1_q.vld <= 1'b0;
			alu2_q.vld <= 1'b0;
			mult_q.vld <= 1'b0;
			agen_q.vld <= 1'b0;
		end else begin
			alu1_q <= alu1_issue;
			alu2_q <= alu2_issue;
			mult_q <= mult_issue;
			agen_q <= agen_issue;
		end
	end

	assign rd_addr[0] = alu1_q.src1;
	assign rd_addr[1] = alu1_q.src2;
	assign rd_addr[2] = alu2_q.src1;
	assign rd_addr[3] = alu2_q.src2;
	assign rd_addr[4] = mult_q.src1;
	assign rd_addr[5] = mult_q.src2;
	// agen only needs the base
	assign rd_addr[6] = agen_q.src1;

	assign agen_addr = rd_data[6] + agen_q.imm;

	// RF/EX
	always_ff @(posedge clk) begin
		if (rst) begin
			alu1_op.vld <= 1'b0;
			alu2_op.vld <= 1'b0;
			mult_op.vld <= 1'b0;
			agen_op.vld <= 1'b0;
		end else begin
			alu1_op <= to_exec(alu1_q, rd_data[0], rd_data[1]);
			alu2_op <= to_exec(alu2_q, rd_data[2], rd_data[3]);
			mult_op <= to_exec(mult_q, rd_data[4], rd_data[5]);
			agen_op <= '{vld: agen_q.vld, rob_idx: agen_q.rob_idx, addr: agen_addr};
		end
	end

endmodule

//--- alu_unit.sv
`timescale 1ns/10ps

module alu_unit import exec_pkg::*; (
	input  exec_op_t op_in,
	output data_t    result
);

	logic [3:0] shamt;

	// only the low nibble of opb matters for shifts
	assign shamt = op_in.opb[3:0];

	always_comb begin
		case (op_in.op)
			ADD: begin
				result = op_in.opa + op_in.opb;
			end
			SUB: begin
				result = op_in.opa - op_in.opb;
			end
			AND: begin
				result = op_in.opa & op_in.opb;
			end
			OR: begin
				result = op_in.opa | op_in.opb;
			end
			XOR: begin
				result = op_in.opa ^ op_in.opb;
			end
			SLL: begin
				result = op_in.opa << shamt;
			end
			SRL: begin
				// logical, zero fill
				result = op_in.opa >> shamt;
			end
			LDI: begin
				result = op_in.opb;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

//--- mult_unit.sv
`timescale 1ns/10ps

module mult_unit import exec_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  exec_op_t op_in,
	output done_t    done
);

	data_t       pp_lo;
	logic [7:0]  pp_hi;
	logic [7:0]  pp_hi_q;
	done_t       stg_q [MULT_STAGES];

	// split opb by byte
	// only the low byte of the upper partial lands in a 16-bit result
	assign pp_lo = op_in.opa * {8'h00, op_in.opb[7:0]};
	assign pp_hi = op_in.opa[7:0] * op_in.opb[15:8];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MULT_STAGES; i++) begin
				stg_q[i].vld <= 1'b0;
			end
		end else begin
			stg_q[0] <= '{
				vld:     op_in.vld,
				rob_idx: op_in.rob_idx,
				reg_wrt: op_in.reg_wrt,
				dst:     op_in.dst,
				data:    pp_lo
			};
			pp_hi_q <= pp_hi;

			// second stage folds in the shifted upper partial
			stg_q[1]      <= stg_q[0];
			stg_q[1].data <= stg_q[0].data + {pp_hi_q, 8'h00};

			for (int i = 2; i < MULT_STAGES; i++) begin
				stg_q[i] <= stg_q[i-1];
			end
		end
	end

	assign done = stg_q[MULT_STAGES-1];

	// tag and product leave together after a fixed latency
	a_mult_latency: assert property (@(posedge clk) disable iff (rst)
		op_in.vld |-> ##MULT_STAGES
			(done.vld && (done.rob_idx == $past(op_in.rob_idx, MULT_STAGES))
				&& (done.data == $past(data_t'(op_in.opa * op_in.opb), MULT_STAGES))))
		else $error("mult result missing, out of order or wrong");

	a_mult_no_spurious: assert property (@(posedge clk) disable iff (rst)
		done.vld |-> $past(op_in.vld, MULT_STAGES))
		else $error("mult done without a matching issue");

endmodule

//--- exec_cluster.sv
`timescale 1ns/10ps

module exec_cluster import exec_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  exec_op_t alu1_op,
	input  exec_op_t alu2_op,
	input  exec_op_t mult_op,
	input  agen_t    agen_op,
	output done_t    alu1_done,
	output done_t    alu2_done,
	output done_t    mult_done,
	output agen_t    agen_done,
	output wr_req_t  wr_req [WR_PORTS]
);

	data_t alu1_res;
	data_t alu2_res;
	done_t mult_res;

	function automatic done_t to_done(input exec_op_t o, input data_t r);
		return '{vld: o.vld, rob_idx: o.rob_idx, reg_wrt: o.reg_wrt, dst: o.dst, data: r};
	endfunction

	function automatic wr_req_t to_wr(input done_t d);
		return '{en: d.vld & d.reg_wrt, dst: d.dst, data: d.data};
	endfunction

	alu_unit u_alu1 (.op_in(alu1_op), .result(alu1_res));
	alu_unit u_alu2 (.op_in(alu2_op), .result(alu2_res));

	mult_unit u_mult (
		.clk   (clk),
		.rst   (rst),
		.op_in (mult_op),
		.done  (mult_res)
	);

	// EX/WB latch
	// agen gets one delay to line up with the alus
	always_ff @(posedge clk) begin
		if (rst) begin
			alu1_done.vld <= 1'b0;
			alu2_done.vld <= 1'b0;
			mult_done.vld <= 1'b0;
			agen_done.vld <= 1'b0;
		end else begin
			alu1_done <= to_done(alu1_op, alu1_res);
			alu2_done <= to_done(alu2_op, alu2_res);
			mult_done <= mult_res;
			agen_done <= agen_op;
		end
	end

	assign wr_req[0] = to_wr(alu1_done);
	assign wr_req[1] = to_wr(alu2_done);
	assign wr_req[2] = to_wr(mult_done);

endmodule

//--- exec_core_top.sv
`timescale 1ns/10ps

module exec_core_top import exec_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  issue_pkt_t alu1_issue,
	input  issue_pkt_t alu2_issue,
	input  issue_pkt_t mult_issue,
	input  issue_pkt_t agen_issue,
	output done_t      alu1_done,
	output done_t      alu2_done,
	output done_t      mult_done,
	output agen_t      agen_done
);

	preg_t    rd_addr [RD_PORTS];
	data_t    rd_data [RD_PORTS];
	wr_req_t  wr_req  [WR_PORTS];
	exec_op_t alu1_op;
	exec_op_t alu2_op;
	exec_op_t mult_op;
	agen_t    agen_op;

	operand_fetch u_operand_fetch (
		.clk        (clk),
		.rst        (rst),
		.alu1_issue (alu1_issue),
		.alu2_issue (alu2_issue),
		.mult_issue (mult_issue),
		.agen_issue (agen_issue),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.alu1_op    (alu1_op),
		.alu2_op    (alu2_op),
		.mult_op    (mult_op),
		.agen_op    (agen_op)
	);

	phys_reg_file u_phys_reg_file (
		.clk     (clk),
		.rst     (rst),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.wr_req  (wr_req)
	);

	exec_cluster u_exec_cluster (
		.clk       (clk),
		.rst       (rst),
		.alu1_op   (alu1_op),
		.alu2_op   (alu2_op),
		.mult_op   (mult_op),
		.agen_op   (agen_op),
		.alu1_done (alu1_done),
		.alu2_done (alu2_done),
		.mult_done (mult_done),
		.agen_done (agen_done),
		.wr_req    (wr_req)
	);

endmodule

//--- exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// expected done and the falling-edge cycle it is due on
typedef struct {
	int    due;
	done_t res;
} done_rec_t;

typedef struct {
	int    due;
	agen_t res;
} agen_rec_t;

data_t     model_regs [PREG_NUM];
int        ready_cyc  [PREG_NUM];
bit        pending    [PREG_NUM];
done_rec_t alu1_exp   [$];
done_rec_t alu2_exp   [$];
done_rec_t mult_exp   [$];
agen_rec_t agen_exp   [$];

function automatic data_t alu_ref(input alu_op_e op, input data_t a, input data_t b);
	case (op)
		ADD: return a + b;
		SUB: return a - b;
		AND: return a & b;
		OR:  return a | b;
		XOR: return a ^ b;
		SLL: return a << b[3:0];
		SRL: return a >> b[3:0];
		default: return b;
	endcase
endfunction

function automatic data_t mult_ref(input data_t a, input data_t b);
	logic [31:0] p;
	p = a * b;
	return p[15:0];
endfunction

task automatic reset_model();
	for (int i = 0; i < PREG_NUM; i++) begin
		model_regs[i] = '0;
		ready_cyc[i]  = 0;
		pending[i]    = 1'b0;
	end
	alu1_exp.delete();
	alu2_exp.delete();
	mult_exp.delete();
	agen_exp.delete();
endtask

// regfile write lands on the next rising edge
task automatic retire(input done_t d);
	if (d.reg_wrt) begin
		model_regs[d.dst] = d.data;
		pending[d.dst]    = 1'b0;
	end
endtask

function automatic bit lanes_busy();
	return (alu1_exp.size() + alu2_exp.size() + mult_exp.size() + agen_exp.size()) != 0;
endfunction

`endif

//--- tb_exec_core.sv
`timescale 1ns/10ps

module tb_exec_core import exec_pkg::*; ();

	localparam int CLK_NS   = 8;
	localparam int RUN_CYC  = 20 + 200 + 100 + 100 + 30 + 400;
	localparam int WDOG_CYC = 10 + RUN_CYC + 6 * 10 + 100;

	logic       clk;
	logic       rst;
	issue_pkt_t alu1_issue;
	issue_pkt_t alu2_issue;
	issue_pkt_t mult_issue;
	issue_pkt_t agen_issue;
	done_t      alu1_done;
	done_t      alu2_done;
	done_t      mult_done;
	agen_t      agen_done;

	logic [31:0] lcg_state = 32'h610f;
	rob_idx_t    rob_next;
	int          cyc;
	int          checks;
	int          errors;
	int          tests_failed;
	int          test_num;
	int          test_err0;

	`include "exec_model.svh"

	exec_core_top u_exec_core_top (
		.clk        (clk),
		.rst        (rst),
		.alu1_issue (alu1_issue),
		.alu2_issue (alu2_issue),
		.mult_issue (mult_issue),
		.agen_issue (agen_issue),
		.alu1_done  (alu1_done),
		.alu2_done  (alu2_done),
		.mult_done  (mult_done),
		.agen_done  (agen_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#(WDOG_CYC * CLK_NS);
		$display("watchdog expired after %0d cycles, the run never finished", WDOG_CYC);
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic preg_t pick_src();
		preg_t r;
		do begin
			r = preg_t'(next_rand());
		end while (ready_cyc[r] > cyc);
		return r;
	endfunction

	// only a dozen or so pregs are ever pending
	function automatic preg_t pick_dst();
		preg_t r;
		do begin
			r = preg_t'(next_rand());
		end while (pending[r]);
		return r;
	endfunction

	function automatic string done_text(input done_t d);
		return $sformatf("vld %b rob %0d wrt %b dst %0d data %h",
			d.vld, d.rob_idx, d.reg_wrt, d.dst, d.data);
	endfunction

	task automatic check_done(input string lane, input done_t got, input done_t exp);
		checks++;
		if (exp.vld ? (got !== exp) : (got.vld !== 1'b0)) begin
			errors++;
			$display("Fail %0t: %s done %s, expected %s",
				$time, lane, done_text(got), done_text(exp));
		end
	endtask

	task automatic check_agen(input agen_t got, input agen_t exp);
		checks++;
		if (exp.vld ? (got !== exp) : (got.vld !== 1'b0)) begin
			errors++;
			$display("Fail %0t: agen done vld %b rob %0d addr %h, expected vld %b rob %0d addr %h",
				$time, got.vld, got.rob_idx, got.addr, exp.vld, exp.rob_idx, exp.addr);
		end
	endtask

	task automatic check_lane(input string lane, input done_t got, ref done_rec_t q[$]);
		done_t idle;
		idle = '0;
		if (q.size() > 0 && q[0].due == cyc) begin
			check_done(lane, got, q[0].res);
			retire(q[0].res);
			void'(q.pop_front());
		end else begin
			check_done(lane, got, idle);
		end
	endtask

	// one falling edge checks every lane, then idles the issue ports
	task automatic step();
		agen_t idle_agen;
		idle_agen = '0;
		@(negedge clk);
		cyc++;
		check_lane("alu1", alu1_done, alu1_exp);
		check_lane("alu2", alu2_done, alu2_exp);
		check_lane("mult", mult_done, mult_exp);
		if (agen_exp.size() > 0 && agen_exp[0].due == cyc) begin
			check_agen(agen_done, agen_exp[0].res);
			void'(agen_exp.pop_front());
		end else begin
			check_agen(agen_done, idle_agen);
		end
		alu1_issue = '0;
		alu2_issue = '0;
		mult_issue = '0;
		agen_issue = '0;
	endtask

	task automatic issue_alu(input int lane, input alu_op_e op, input preg_t s1, input preg_t s2,
			input preg_t dst, input logic wrt, input logic immv, input data_t imm);
		issue_pkt_t p;
		done_rec_t  r;
		data_t      b;
		p = '{vld: 1'b1, rob_idx: rob_next, src1: s1, src2: s2, dst: dst, reg_wrt: wrt,
			imm_vld: immv, imm: imm, op: op};
		b = immv ? imm : model_regs[s2];
		r.due = cyc + 3;
		r.res = '{vld: 1'b1, rob_idx: rob_next, reg_wrt: wrt, dst: dst,
			data: alu_ref(op, model_regs[s1], b)};
		rob_next++;
		if (wrt) begin
			pending[dst]   = 1'b1;
			ready_cyc[dst] = cyc + 4;
		end
		if (lane == 1) begin
			alu1_issue = p;
			alu1_exp.push_back(r);
		end else begin
			alu2_issue = p;
			alu2_exp.push_back(r);
		end
	endtask

	task automatic issue_mult(input preg_t s1, input preg_t s2, input preg_t dst, input logic wrt);
		done_rec_t r;
		mult_issue = '{vld: 1'b1, rob_idx: rob_next, src1: s1, src2: s2, dst: dst, reg_wrt: wrt,
			imm_vld: 1'b0, imm: '0, op: ADD};
		r.due = cyc + 5;
		r.res = '{vld: 1'b1, rob_idx: rob_next, reg_wrt: wrt, dst: dst,
			data: mult_ref(model_regs[s1], model_regs[s2])};
		rob_next++;
		if (wrt) begin
			pending[dst]   = 1'b1;
			ready_cyc[dst] = cyc + 6;
		end
		mult_exp.push_back(r);
	endtask

	task automatic issue_agen(input preg_t base, input data_t imm);
		agen_rec_t r;
		agen_issue = '{vld: 1'b1, rob_idx: rob_next, src1: base, src2: '0, dst: '0,
			reg_wrt: 1'b0, imm_vld: 1'b1, imm: imm, op: ADD};
		r.due = cyc + 3;
		r.res = '{vld: 1'b1, rob_idx: rob_next, addr: model_regs[base] + imm};
		rob_next++;
		agen_exp.push_back(r);
	endtask

	task automatic rand_alu(input int lane);
		logic [15:0] c;
		c = next_rand();
		issue_alu(lane, alu_op_e'(c[2:0]), pick_src(), pick_src(), pick_dst(),
			c[15:13] != 3'b000, c[3], next_rand());
	endtask

	task automatic rand_mult();
		logic [15:0] c;
		c = next_rand();
		issue_mult(pick_src(), pick_src(), pick_dst(), c[15:13] != 3'b000);
	endtask

	task automatic begin_test();
		test_num++;
		test_err0 = errors;
	endtask

	task automatic end_test(input string name);
		while (lanes_busy()) begin
			step();
		end
		step();
		if (errors != test_err0) begin
			tests_failed++;
		end
		$display("test %0d %s: %0d mismatches", test_num, name, errors - test_err0);
	endtask

	initial begin
		logic [15:0] mix;
		rst          = 1'b1;
		alu1_issue   = '0;
		alu2_issue   = '0;
		mult_issue   = '0;
		agen_issue   = '0;
		rob_next     = '0;
		cyc          = 0;
		checks       = 0;
		errors       = 0;
		tests_failed = 0;
		test_num     = 0;
		reset_model();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// idle outputs first, then fill pregs 0..31
		begin_test();
		repeat (4) step();
		for (int i = 0; i < 16; i++) begin
			step();
			issue_alu(1, LDI, '0, '0, preg_t'(2 * i), 1'b1, 1'b1, next_rand());
			issue_alu(2, LDI, '0, '0, preg_t'(2 * i + 1), 1'b1, 1'b1, next_rand());
		end
		end_test("reset and ldi");

		begin_test();
		repeat (200) begin
			step();
			rand_alu(1);
			rand_alu(2);
		end
		end_test("random alu");

		begin_test();
		repeat (100) begin
			step();
			rand_mult();
		end
		end_test("random mult");

		begin_test();
		repeat (100) begin
			step();
			issue_agen(pick_src(), next_rand());
		end
		end_test("random agen");

		// back-to-back dependencies at the minimum issue distance
		begin_test();
		step();
		issue_alu(1, LDI, '0, '0, 6'd40, 1'b1, 1'b1, 16'h1234);
		repeat (4) step();
		issue_alu(2, ADD, 6'd40, 6'd40, 6'd41, 1'b1, 1'b0, '0);
		repeat (4) step();
		issue_mult(6'd41, 6'd40, 6'd42, 1'b1);
		repeat (6) step();
		issue_alu(1, XOR, 6'd42, 6'd40, 6'd43, 1'b1, 1'b0, '0);
		repeat (4) step();
		issue_alu(2, LDI, '0, '0, 6'd43, 1'b0, 1'b1, 16'hdead);
		repeat (4) step();
		issue_alu(1, ADD, 6'd43, '0, 6'd44, 1'b1, 1'b1, '0);
		end_test("dependency distance");

		begin_test();
		repeat (400) begin
			step();
			mix = next_rand();
			if (mix[1:0] != 2'b00) begin
				rand_alu(1);
			end
			if (mix[3:2] != 2'b00) begin
				rand_alu(2);
			end
			if (mix[5:4] != 2'b00) begin
				rand_mult();
			end
			if (mix[7:6] != 2'b00) begin
				issue_agen(pick_src(), next_rand());
			end
		end
		end_test("mixed lanes");

		$display("tests %0d, failed %0d, checks %0d, mismatches %0d",
			test_num, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+.
exec_pkg.sv
phys_reg_file.sv
operand_fetch.sv
alu_unit.sv
mult_unit.sv
exec_cluster.sv
exec_core_top.sv
tb_exec_core.sv
